//--- common/cpu_defs.svh
// CPU sizing defines
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath word width
`define CPU_XLEN 32

// Architectural register count
`define CPU_NREGS 16

// Memory depths in words
`define CPU_IMEM_DEPTH 256
`define CPU_DMEM_DEPTH 256

// Address widths, matched to the depths above
`define CPU_PC_W 8
`define CPU_DADDR_W 8

`endif

//--- common/cpuIsaPkg.sv
// CPU instruction set types
package cpuIsaPkg;

  // Opcode field, bits 27 to 24
  typedef enum logic [3:0] {
    AND  = 4'h0,
    EOR  = 4'h1,
    SUB  = 4'h2,
    ADD  = 4'h3,
    ORR  = 4'h4,
    MOV  = 4'h5,  // Zero-extended 16-bit immediate
    LSL  = 4'h6,
    LSR  = 4'h7,
    ROR  = 4'h8,
    CMP  = 4'h9,  // Subtract, flags only
    LDR  = 4'ha,
    STR  = 4'hb,
    B    = 4'hc,  // Absolute target, low byte of immediate
    NOPD = 4'hd,
    NOPE = 4'he,
    HALT = 4'hf
  } opcodeT;

  // ARM-style condition codes on NZCV
  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } condT;

  // Instruction layout, MSB first
  typedef struct packed {
    condT       cond;      // 31:28
    opcodeT     opcode;    // 27:24
    logic       setFlags;  // 23
    logic [3:0] rd;        // 22:19
    logic [3:0] rs2;       // 18:15, also top of move immediate
    logic [3:0] rs1;       // 14:11
    logic [4:0] shamt;     // 10:6, shift amount or memory offset
    logic [5:0] low;       // 5:0, bits 5:3 end the move immediate
  } instrT;

  // Status flags
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

endpackage

//--- common/cpuDataPkg.sv
// CPU datapath types
`include "cpu_defs.svh"

package cpuDataPkg;

  // Data word
  typedef logic [`CPU_XLEN-1:0] wordT;

  // Register bank index
  typedef logic [$clog2(`CPU_NREGS)-1:0] regIdxT;

  // Instruction RAM address
  typedef logic [`CPU_PC_W-1:0] pcT;

  // Data RAM address
  typedef logic [`CPU_DADDR_W-1:0] dAddrT;

endpackage

//--- common/cpuIfs.sv
// CPU internal port bundles
`timescale 1ns/100ps

// Register bank access, two reads and one write
interface regPortIf;
  cpuDataPkg::regIdxT rdAddrA;
  cpuDataPkg::regIdxT rdAddrB;
  cpuDataPkg::wordT   rdDataA;
  cpuDataPkg::wordT   rdDataB;
  logic               wrEn;
  cpuDataPkg::regIdxT wrAddr;
  cpuDataPkg::wordT   wrData;

  modport reader (output rdAddrA, output rdAddrB, input rdDataA, input rdDataB);  // Control

  modport writer (output wrEn, output wrAddr, output wrData);  // Write-back

  modport bank (
    input  rdAddrA, rdAddrB,
    input  wrEn, wrAddr, wrData,
    output rdDataA, rdDataB
  );
endinterface

// Data RAM access, combinational read while en
interface memPortIf;
  logic              en;
  logic              we;
  cpuDataPkg::dAddrT addr;
  cpuDataPkg::wordT  wdata;
  cpuDataPkg::wordT  rdata;

  modport master (output en, output we, output addr, output wdata, input rdata);

  modport slave (input en, input we, input addr, input wdata, output rdata);
endinterface

//--- hw/wordRam.sv
// Single-port word RAM
`timescale 1ns/100ps

module wordRam #(
  parameter type wordT = logic [31:0],     // Stored payload
  parameter int  Depth = 64,               // Words
  parameter int  AddrW = $clog2(Depth)
) (
  input  logic             Clk_i,
  input  logic             en_i,
  input  logic             we_i,
  input  logic [AddrW-1:0] addr_i,
  input  wordT             wdata_i,
  output wordT             rdata_o
);

  wordT mem [Depth];  // Storage, contents undefined until written

  // Write on the clock edge
  always_ff @(posedge Clk_i)
  begin
    if (en_i && we_i)
    begin
      mem[addr_i] <= wdata_i;
    end
  end

  assign rdata_o = en_i ? mem[addr_i] : wordT'('0);  // Async read, zero while disabled

  // Access must stay inside the array
  addrInRange: assert property (@(posedge Clk_i) en_i |-> (int'(addr_i) < Depth))
    else $error("wordRam access beyond depth at address %0h", addr_i);

endmodule

//--- hw/regBank.sv
// 16-entry register bank
`timescale 1ns/100ps
`include "cpu_defs.svh"

module regBank (
  input  logic               Clk_i,
  input  logic               rstN_i,
  regPortIf.bank             regs,
  input  cpuDataPkg::regIdxT dbgAddr_i,   // Testbench readback
  output cpuDataPkg::wordT   dbgData_o
);

  cpuDataPkg::wordT regFile [`CPU_NREGS];  // r0 is a normal register

  // One write per cycle, all cleared in reset
  always_ff @(posedge Clk_i)
  begin
    if (!rstN_i)
    begin
      for (int i = 0; i < `CPU_NREGS; i++)
      begin
        regFile[i] <= '0;
      end
    end
    else if (regs.wrEn)
    begin
      regFile[regs.wrAddr] <= regs.wrData;
    end
  end

  // Combinational reads, no write bypass
  assign regs.rdDataA = regFile[regs.rdAddrA];
  assign regs.rdDataB = regFile[regs.rdAddrB];
  assign dbgData_o    = regFile[dbgAddr_i];  // Debug port

  // Write-back from memControl must carry a known index
  wrAddrKnown: assert property (@(posedge Clk_i) disable iff (!rstN_i)
    regs.wrEn |-> !$isunknown(regs.wrAddr))
    else $error("regBank write with unknown address");

endmodule

//--- hw/alu/masterAlu.sv
// ALU with flag and condition logic
`timescale 1ns/100ps
`include "cpu_defs.svh"

module masterAlu (
  input  cpuIsaPkg::instrT instr_i,
  input  cpuDataPkg::wordT opA_i,       // rs1
  input  cpuDataPkg::wordT opB_i,       // rs2
  input  cpuIsaPkg::flagsT flags_i,     // Current NZCV
  output cpuDataPkg::wordT result_o,
  output cpuIsaPkg::flagsT newFlags_o,
  output logic             condPass_o
);

  logic [`CPU_XLEN:0]     addSum;   // Carry out in MSB
  logic [`CPU_XLEN:0]     subDiff;  // MSB set means no borrow
  logic [`CPU_XLEN:0]     lslExt;   // Last bit out in MSB
  logic [`CPU_XLEN:0]     lsrExt;   // Last bit out in LSB
  logic [2*`CPU_XLEN-1:0] rorExt;
  logic [15:0]            movImm;
  logic                   shiftZero;
  logic                   carry;
  logic                   ovf;
  logic                   aluOp;    // Opcode produces ALU flags
  cpuDataPkg::wordT       result;

  // Move immediate spans instruction bits 18:3
  assign movImm = {instr_i.rs2, instr_i.rs1, instr_i.shamt, instr_i.low[5:3]};

  assign addSum    = {1'b0, opA_i} + {1'b0, opB_i};
  assign subDiff   = {1'b0, opA_i} + {1'b0, ~opB_i} + 1'b1;  // Two's complement subtract
  assign lslExt    = {1'b0, opA_i} << instr_i.shamt;
  assign lsrExt    = {opA_i, 1'b0} >> instr_i.shamt;
  assign rorExt    = {opA_i, opA_i} >> instr_i.shamt;        // Rotate by doubling
  assign shiftZero = (instr_i.shamt == '0);                   // No bit shifted out

  always_comb
  begin
    result = '0;
    carry  = flags_i.c;  // Kept unless the op defines it
    ovf    = flags_i.v;
    aluOp  = 1'b1;
    unique case (instr_i.opcode)
      cpuIsaPkg::AND: result = opA_i & opB_i;
      cpuIsaPkg::EOR: result = opA_i ^ opB_i;
      cpuIsaPkg::ORR: result = opA_i | opB_i;
      cpuIsaPkg::MOV: result = cpuDataPkg::wordT'(movImm);  // Zero-extended
      cpuIsaPkg::ADD:
      begin
        result = addSum[`CPU_XLEN-1:0];
        carry  = addSum[`CPU_XLEN];
        // Same-sign operands, result sign differs
        ovf    = (opA_i[`CPU_XLEN-1] == opB_i[`CPU_XLEN-1]) &&
                 (result[`CPU_XLEN-1] != opA_i[`CPU_XLEN-1]);
      end
      cpuIsaPkg::SUB, cpuIsaPkg::CMP:
      begin
        result = subDiff[`CPU_XLEN-1:0];
        carry  = subDiff[`CPU_XLEN];
        ovf    = (opA_i[`CPU_XLEN-1] != opB_i[`CPU_XLEN-1]) &&
                 (result[`CPU_XLEN-1] != opA_i[`CPU_XLEN-1]);
      end
      cpuIsaPkg::LSL:
      begin
        result = lslExt[`CPU_XLEN-1:0];
        carry  = shiftZero ? flags_i.c : lslExt[`CPU_XLEN];
      end
      cpuIsaPkg::LSR:
      begin
        result = lsrExt[`CPU_XLEN:1];
        carry  = shiftZero ? flags_i.c : lsrExt[0];
      end
      cpuIsaPkg::ROR:
      begin
        result = rorExt[`CPU_XLEN-1:0];
        carry  = shiftZero ? flags_i.c : result[`CPU_XLEN-1];  // Last bit rotated round
      end
      default: aluOp = 1'b0;  // Memory, branch, HALT and no-ops
    endcase
  end

  assign result_o   = result;
  assign newFlags_o = aluOp ? '{n: result[`CPU_XLEN-1], z: (result == '0), c: carry, v: ovf}
                            : flags_i;  // Non-ALU ops leave NZCV alone

  // Condition check on the current flags
  always_comb
  begin
    unique case (instr_i.cond)
      cpuIsaPkg::EQ: condPass_o = flags_i.z;
      cpuIsaPkg::NE: condPass_o = !flags_i.z;
      cpuIsaPkg::CS: condPass_o = flags_i.c;
      cpuIsaPkg::CC: condPass_o = !flags_i.c;
      cpuIsaPkg::MI: condPass_o = flags_i.n;
      cpuIsaPkg::PL: condPass_o = !flags_i.n;
      cpuIsaPkg::VS: condPass_o = flags_i.v;
      cpuIsaPkg::VC: condPass_o = !flags_i.v;
      cpuIsaPkg::HI: condPass_o = flags_i.c && !flags_i.z;          // Unsigned higher
      cpuIsaPkg::LS: condPass_o = !flags_i.c || flags_i.z;
      cpuIsaPkg::GE: condPass_o = (flags_i.n == flags_i.v);         // Signed compares
      cpuIsaPkg::LT: condPass_o = (flags_i.n != flags_i.v);
      cpuIsaPkg::GT: condPass_o = !flags_i.z && (flags_i.n == flags_i.v);
      cpuIsaPkg::LE: condPass_o = flags_i.z || (flags_i.n != flags_i.v);
      cpuIsaPkg::AL: condPass_o = 1'b1;
      default:       condPass_o = 1'b0;  // NV never executes
    endcase
  end

endmodule

//--- hw/memControl.sv
// Load/store and write-back control
`timescale 1ns/100ps

module memControl (
  input  logic             Clk_i,
  input  logic             exec_i,       // Instruction retires this cycle
  input  cpuIsaPkg::instrT instr_i,
  input  cpuDataPkg::wordT opA_i,        // Base register
  input  cpuDataPkg::wordT opB_i,        // Store data
  input  cpuDataPkg::wordT aluResult_i,
  memPortIf.master         mem,
  regPortIf.writer         regs
);

  cpuDataPkg::wordT effAddr;
  logic             isLdr;
  logic             isStr;
  logic             wbOp;  // Opcode writes rd

  assign isLdr   = (instr_i.opcode == cpuIsaPkg::LDR);
  assign isStr   = (instr_i.opcode == cpuIsaPkg::STR);
  assign effAddr = opA_i + cpuDataPkg::wordT'(instr_i.shamt);  // Base plus offset

  always_comb
  begin
    unique case (instr_i.opcode)
      cpuIsaPkg::AND, cpuIsaPkg::EOR, cpuIsaPkg::SUB, cpuIsaPkg::ADD,
      cpuIsaPkg::ORR, cpuIsaPkg::MOV, cpuIsaPkg::LSL, cpuIsaPkg::LSR,
      cpuIsaPkg::ROR, cpuIsaPkg::LDR: wbOp = 1'b1;
      default:                        wbOp = 1'b0;  // CMP, STR, B, HALT, no-ops
    endcase
  end

  // Data RAM side
  assign mem.en    = exec_i && (isLdr || isStr);
  assign mem.we    = exec_i && isStr;
  assign mem.addr  = cpuDataPkg::dAddrT'(effAddr);  // Wraps at 256 words
  assign mem.wdata = opB_i;

  // Register write-back
  assign regs.wrEn   = exec_i && wbOp;
  assign regs.wrAddr = instr_i.rd;
  assign regs.wrData = isLdr ? mem.rdata : aluResult_i;

  // A store retires with no register update
  storeNoWb: assert property (@(posedge Clk_i) mem.we |-> !regs.wrEn)
    else $error("Store and register write in the same cycle");

endmodule

//--- hw/control/cpuControl.sv
// PC, run state and flag register
`timescale 1ns/100ps

module cpuControl (
  input  logic             Clk_i,
  input  logic             rstN_i,
  input  logic             run_i,       // Start pulse, ignored while running
  input  cpuIsaPkg::instrT instr_i,
  input  logic             condPass_i,
  input  cpuIsaPkg::flagsT newFlags_i,
  regPortIf.reader         regs,
  output cpuDataPkg::pcT   pc_o,
  output cpuIsaPkg::flagsT flags_o,
  output logic             exec_o,      // Current instruction takes effect
  output logic             halted_o
);

  logic             running;
  logic             halted;
  cpuDataPkg::pcT   pc;
  cpuIsaPkg::flagsT flags;
  cpuDataPkg::pcT   brTarget;
  logic             isHalt;
  logic             isBranch;
  logic             flagLoad;

  assign isHalt   = (instr_i.opcode == cpuIsaPkg::HALT);
  assign isBranch = (instr_i.opcode == cpuIsaPkg::B);
  assign brTarget = {instr_i.shamt, instr_i.low[5:3]};  // Immediate bits 7:0

  assign exec_o   = running && condPass_i;
  assign flagLoad = exec_o && (instr_i.setFlags || (instr_i.opcode == cpuIsaPkg::CMP));

  always_ff @(posedge Clk_i)
  begin
    if (!rstN_i)
    begin
      running <= 1'b0;
      halted  <= 1'b0;
      pc      <= '0;
      flags   <= '0;
    end
    else if (!running)
    begin
      if (run_i)  // Fresh start from address zero
      begin
        running <= 1'b1;
        halted  <= 1'b0;
        pc      <= '0;
        flags   <= '0;
      end
    end
    else
    begin
      if (exec_o && isHalt)
      begin
        running <= 1'b0;  // pc stays on the HALT
        halted  <= 1'b1;
      end
      else if (exec_o && isBranch)
      begin
        pc <= brTarget;
      end
      else
      begin
        pc <= pc + 1'b1;  // Also taken by failed conditions
      end
      if (flagLoad)
      begin
        flags <= newFlags_i;
      end
    end
  end

  // Operand steering, STR reads rd as its store data
  assign regs.rdAddrA = instr_i.rs1;
  assign regs.rdAddrB = (instr_i.opcode == cpuIsaPkg::STR) ? instr_i.rd : instr_i.rs2;

  assign pc_o     = pc;
  assign flags_o  = flags;
  assign halted_o = halted;

  // pc holds between runs
  pcIdleStable: assert property (@(posedge Clk_i) disable iff (!rstN_i)
    (!running && !run_i) |=> $stable(pc))
    else $error("pc moved while idle");

endmodule

//--- hw/masterCpu.sv
// Single-cycle load/store CPU top
`timescale 1ns/100ps
`include "cpu_defs.svh"

module masterCpu (
  input  logic                 Clk_i,
  input  logic                 rstN_i,
  input  logic                 progWe_i,      // Program load strobe
  input  cpuDataPkg::pcT       progAddr_i,
  input  logic [`CPU_XLEN-1:0] progData_i,
  input  logic                 run_i,
  input  logic [3:0]           dbgRegAddr_i,
  output logic [`CPU_XLEN-1:0] dbgRegData_o,
  output logic [3:0]           flags_o,       // NZCV
  output logic [`CPU_PC_W-1:0] pc_o,
  output logic                 halted_o
);

  regPortIf regs ();
  memPortIf dMem ();

  cpuIsaPkg::instrT instr;
  cpuIsaPkg::flagsT flags;
  cpuIsaPkg::flagsT newFlags;
  cpuDataPkg::pcT   pc;
  cpuDataPkg::pcT   iAddr;
  cpuDataPkg::wordT aluResult;
  logic             condPass;
  logic             exec;

  assign iAddr = progWe_i ? progAddr_i : pc;  // Loader owns the port while writing

  // Instruction RAM, enabled out of reset
  wordRam #(.wordT(cpuIsaPkg::instrT), .Depth(`CPU_IMEM_DEPTH)) u_iMem (
    .Clk_i, .en_i(rstN_i), .we_i(progWe_i), .addr_i(iAddr),
    .wdata_i(cpuIsaPkg::instrT'(progData_i)), .rdata_o(instr)
  );

  // Data RAM, slave end of dMem
  wordRam #(.wordT(cpuDataPkg::wordT), .Depth(`CPU_DMEM_DEPTH)) u_dMem (
    .Clk_i, .en_i(dMem.en), .we_i(dMem.we), .addr_i(dMem.addr),
    .wdata_i(dMem.wdata), .rdata_o(dMem.rdata)
  );

  regBank u_regBank (.Clk_i, .rstN_i, .regs(regs.bank), .dbgAddr_i(dbgRegAddr_i),
    .dbgData_o(dbgRegData_o));

  masterAlu u_alu (.instr_i(instr), .opA_i(regs.rdDataA), .opB_i(regs.rdDataB),
    .flags_i(flags), .result_o(aluResult), .newFlags_o(newFlags), .condPass_o(condPass));

  memControl u_memControl (.Clk_i, .exec_i(exec), .instr_i(instr), .opA_i(regs.rdDataA),
    .opB_i(regs.rdDataB), .aluResult_i(aluResult), .mem(dMem.master), .regs(regs.writer));

  cpuControl u_control (.Clk_i, .rstN_i, .run_i, .instr_i(instr), .condPass_i(condPass),
    .newFlags_i(newFlags), .regs(regs.reader), .pc_o(pc), .flags_o(flags), .exec_o(exec),
    .halted_o);

  assign flags_o = flags;
  assign pc_o    = pc;

  // Program loads only while the core is idle
  progWhileIdle: assert property (@(posedge Clk_i) disable iff (!rstN_i)
    progWe_i |-> !u_control.running)
    else $error("Program write while running");

endmodule

//--- bench/tbMasterCpu.sv
// Single-cycle CPU testbench
`timescale 1ns/100ps

module tbMasterCpu;

  localparam logic [3:0] CondAl = 4'he;  // Always
  localparam logic [3:0] CondNv = 4'hf;  // Never

  logic        clk;
  logic        rstN;
  logic        progWe;
  logic [7:0]  progAddr;
  logic [31:0] progData;
  logic        run;
  logic [3:0]  dbgRegAddr;
  logic [31:0] dbgRegData;
  logic [3:0]  flags;
  logic [7:0]  pc;
  logic        halted;

  logic [31:0] prog [256];  // Program image, shared with the model
  int          progLen;
  logic [31:0] mRegs [16];  // Model state, carried across runs
  logic [31:0] mMem [256];
  logic [3:0]  mFlags;      // NZCV
  logic [7:0]  mHaltPc;
  int          mRetired;
  logic [31:0] lfsr = 32'hd315_1fb4;

  // Stimulus to checker handshake
  int          reqCount;
  int          doneCount;
  string       testName;
  logic        expectRun;
  int          checkCount;
  int          errCount;
  bit          stopped;     // Set once the run is aborted

  masterCpu u_dut (
    .Clk_i(clk), .rstN_i(rstN), .progWe_i(progWe), .progAddr_i(progAddr),
    .progData_i(progData), .run_i(run), .dbgRegAddr_i(dbgRegAddr),
    .dbgRegData_o(dbgRegData), .flags_o(flags), .pc_o(pc), .halted_o(halted)
  );

  always #20 clk = ~clk;  // 40 ns period

  // Galois LFSR, one step per bit
  function automatic logic nextBit();
    logic outBit;
    outBit = lfsr[0];
    lfsr   = {1'b0, lfsr[31:1]} ^ (outBit ? 32'h8020_0003 : 32'h0);
    return outBit;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[30:0], nextBit()};
    end
    return r;
  endfunction

  // Register-operand format
  function automatic logic [31:0] encOp(input logic [3:0] cond, input logic [3:0] op,
      input logic s, input logic [3:0] rd, input logic [3:0] rs2, input logic [3:0] rs1,
      input logic [4:0] sh);
    return {cond, op, s, rd, rs2, rs1, sh, 6'b0};
  endfunction

  // 16-bit immediate in bits 18:3, MOV and B
  function automatic logic [31:0] encImm(input logic [3:0] cond, input logic [3:0] op,
      input logic [3:0] rd, input logic [15:0] imm);
    return {cond, op, 1'b0, rd, imm, 3'b0};
  endfunction

  function automatic void emit(input logic [31:0] w);
    prog[progLen] = w;
    progLen++;
  endfunction

  // ISA-level model, runs prog from address zero on the model state
  function automatic void refRun();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [32:0] wide;
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [4:0]  sh;
    logic [7:0]  mPc;
    logic [7:0]  addr;
    logic        n, z, c, v;
    logic        nc, nv, pass, aluOp, done;
    {n, z, c, v} = 4'b0;  // Flags clear at run
    mPc      = '0;
    done     = 1'b0;
    mRetired = 0;
    for (int steps = 0; steps < 1000 && !done; steps++)
    begin
      ins  = prog[mPc];
      op   = ins[27:24];
      rd   = ins[22:19];
      sh   = ins[10:6];
      a    = mRegs[ins[14:11]];
      b    = mRegs[ins[18:15]];
      addr = 8'(a + 32'(sh));  // Base plus offset, wraps
      mRetired++;
      case (ins[31:28])
        4'h0: pass = z;                    // EQ
        4'h1: pass = !z;
        4'h2: pass = c;                    // CS
        4'h3: pass = !c;
        4'h4: pass = n;                    // MI
        4'h5: pass = !n;
        4'h6: pass = v;                    // VS
        4'h7: pass = !v;
        4'h8: pass = c && !z;              // HI
        4'h9: pass = !c || z;
        4'ha: pass = (n == v);             // GE
        4'hb: pass = (n != v);
        4'hc: pass = !z && (n == v);       // GT
        4'hd: pass = z || (n != v);
        4'he: pass = 1'b1;
        default: pass = 1'b0;              // NV
      endcase
      res   = '0;
      nc    = c;
      nv    = v;
      aluOp = (op <= cpuIsaPkg::CMP);      // AND through CMP
      if (pass)
      begin
        case (op)
          cpuIsaPkg::AND: res = a & b;
          cpuIsaPkg::EOR: res = a ^ b;
          cpuIsaPkg::ORR: res = a | b;
          cpuIsaPkg::MOV: res = {16'h0, ins[18:3]};
          cpuIsaPkg::ADD:
          begin
            wide = {1'b0, a} + {1'b0, b};
            res  = wide[31:0];
            nc   = wide[32];
            nv   = (a[31] == b[31]) && (res[31] != a[31]);
          end
          cpuIsaPkg::SUB, cpuIsaPkg::CMP:
          begin
            res = a - b;
            nc  = (a >= b);                // No borrow
            nv  = (a[31] != b[31]) && (res[31] != a[31]);
          end
          cpuIsaPkg::LSL:
          begin
            res = a << sh;
            if (sh != 0) nc = a[32 - sh];
          end
          cpuIsaPkg::LSR:
          begin
            res = a >> sh;
            if (sh != 0) nc = a[sh - 1];
          end
          cpuIsaPkg::ROR:
          begin
            res = (a >> sh) | (a << (32 - sh));
            if (sh != 0) nc = a[sh - 1];   // Last bit rotated out
          end
          cpuIsaPkg::LDR: mRegs[rd] = mMem[addr];
          cpuIsaPkg::STR: mMem[addr] = mRegs[rd];
          default: res = '0;               // B, HALT, no-ops
        endcase
        if (aluOp && op != cpuIsaPkg::CMP) mRegs[rd] = res;
        if (aluOp && (ins[23] || op == cpuIsaPkg::CMP)) {n, z, c, v} = {res[31], res == 0, nc, nv};
      end
      if (pass && op == cpuIsaPkg::HALT) done = 1'b1;  // pc stays on HALT
      else if (pass && op == cpuIsaPkg::B) mPc = ins[10:3];
      else mPc = mPc + 8'd1;
    end
    mFlags  = {n, z, c, v};
    mHaltPc = mPc;
  endfunction

  task automatic finishRun();
    $display("Tests: %0d, checks: %0d, errors: %0d", doneCount, checkCount, errCount);
    if (errCount == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic abortRun(input string why);
    stopped = 1'b1;
    $display("%s", why);
    errCount++;
    finishRun();
  endtask

  task automatic checkVal(input string name, input logic [31:0] expVal,
      input logic [31:0] actVal);
    checkCount++;
    assert (actVal === expVal)
    else
    begin
      $display("** Error: %s expected 0x%h, got 0x%h", name, expVal, actVal);
      errCount++;
    end
  endtask

  task automatic loadProgram();
    for (int i = 0; i < progLen; i++)
    begin
      @(negedge clk);
      progWe   = 1'b1;
      progAddr = 8'(i);
      progData = prog[i];
    end
    @(negedge clk);
    progWe = 1'b0;
  endtask

  // Hand the test to the checker and wait until it is done
  task automatic requestCheck(input string name, input logic isRun);
    int t;
    testName  = name;
    expectRun = isRun;
    reqCount++;
    t = 0;
    while (doneCount != reqCount && t < 3000)
    begin
      @(negedge clk);
      t++;
    end
    if (doneCount != reqCount)
      abortRun($sformatf("Checker did not finish test %s in time", name));
  endtask

  task automatic runProgram(input string name);
    loadProgram();
    refRun();
    @(negedge clk);
    run = 1'b1;  // One-cycle start pulse
    @(negedge clk);
    run = 1'b0;
    requestCheck(name, 1'b1);
  endtask

  // Build 32-bit operands, then every ALU opcode
  task automatic aluTest();
    progLen = 0;
    for (int i = 1; i <= 4; i++)
    begin
      emit(encImm(CondAl, cpuIsaPkg::MOV, 4'(i), 16'(randBits(16))));
      emit(encOp(CondAl, cpuIsaPkg::LSL, 1'b0, 4'(i), 4'd0, 4'(i), 5'd16));
      emit(encImm(CondAl, cpuIsaPkg::MOV, 4'd13, 16'(randBits(16))));
      emit(encOp(CondAl, cpuIsaPkg::ORR, 1'b0, 4'(i), 4'd13, 4'(i), 5'd0));
    end
    emit(encOp(CondAl, cpuIsaPkg::AND, 1'b0, 4'd5, 4'd2, 4'd1, 5'd0));
    emit(encOp(CondAl, cpuIsaPkg::EOR, 1'b0, 4'd6, 4'd3, 4'd2, 5'd0));
    emit(encOp(CondAl, cpuIsaPkg::SUB, 1'b0, 4'd7, 4'd3, 4'd1, 5'd0));
    emit(encOp(CondAl, cpuIsaPkg::ADD, 1'b1, 4'd8, 4'd4, 4'd2, 5'd0));
    emit(encOp(CondAl, cpuIsaPkg::ORR, 1'b0, 4'd9, 4'd4, 4'd3, 5'd0));
    emit(encOp(CondAl, cpuIsaPkg::LSL, 1'b0, 4'd10, 4'd0, 4'd1, 5'(randBits(5))));
    emit(encOp(CondAl, cpuIsaPkg::LSR, 1'b0, 4'd11, 4'd0, 4'd2, 5'(randBits(5))));
    emit(encOp(CondAl, cpuIsaPkg::ROR, 1'b0, 4'd12, 4'd0, 4'd3, 5'(randBits(5))));
    emit(encOp(CondAl, cpuIsaPkg::CMP, 1'b0, 4'd0, 4'd1, 4'd4, 5'd0));
    emit(encOp(CondAl, cpuIsaPkg::HALT, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0));
    runProgram("ALU opcodes");
  endtask

  // Set flags, then MOV under each of the sixteen conditions
  task automatic condTest(input int k);
    progLen = 0;
    emit(encImm(CondAl, cpuIsaPkg::MOV, 4'd1, 16'(randBits(16))));
    emit(encOp(CondAl, cpuIsaPkg::LSL, 1'b0, 4'd1, 4'd0, 4'd1, 5'd16));
    emit(encImm(CondAl, cpuIsaPkg::MOV, 4'd2, 16'(randBits(16))));
    emit(encOp(CondAl, cpuIsaPkg::LSL, 1'b0, 4'd2, 4'd0, 4'd2, 5'd16));
    case (k % 4)
      0: emit(encOp(CondAl, cpuIsaPkg::CMP, 1'b0, 4'd0, 4'd2, 4'd1, 5'd0));
      1: emit(encOp(CondAl, cpuIsaPkg::ADD, 1'b1, 4'd3, 4'd2, 4'd1, 5'd0));
      2: emit(encOp(CondAl, cpuIsaPkg::SUB, 1'b1, 4'd3, 4'd1, 4'd2, 5'd0));
      default: emit(encOp(CondAl, cpuIsaPkg::CMP, 1'b0, 4'd0, 4'd1, 4'd1, 5'd0));  // Equal
    endcase
    for (int cc = 0; cc < 16; cc++)
    begin
      emit(encImm(4'(cc), cpuIsaPkg::MOV, 4'(cc), 16'(randBits(16))));
    end
    emit(encOp(CondNv, cpuIsaPkg::ADD, 1'b1, 4'd15, 4'd1, 4'd2, 5'd0));  // Must not retire
    emit(encOp(CondAl, cpuIsaPkg::HALT, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0));
    runProgram($sformatf("conditions round %0d", k));
  endtask

  // Four stores at distinct offsets, then loads back
  task automatic memTest();
    logic [4:0] off [4];
    progLen = 0;
    emit(encImm(CondAl, cpuIsaPkg::MOV, 4'd1, 16'(randBits(8))));  // Base address
    for (int j = 0; j < 4; j++)
    begin
      off[j] = 5'(j * 8) + 5'(randBits(3));
      emit(encImm(CondAl, cpuIsaPkg::MOV, 4'(2 + j), 16'(randBits(16))));
      emit(encOp(CondAl, cpuIsaPkg::ROR, 1'b0, 4'(2 + j), 4'd0, 4'(2 + j), 5'(randBits(5))));
      emit(encOp(CondAl, cpuIsaPkg::STR, 1'b0, 4'(2 + j), 4'd0, 4'd1, off[j]));
    end
    for (int j = 0; j < 4; j++)
    begin
      emit(encOp(CondAl, cpuIsaPkg::LDR, 1'b0, 4'(6 + j), 4'd0, 4'd1, off[j]));
    end
    emit(encOp(CondAl, cpuIsaPkg::HALT, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0));
    runProgram("store and load");
  endtask

  task automatic branchTest();
    progLen = 0;
    emit(encImm(CondAl, cpuIsaPkg::MOV, 4'd1, 16'(randBits(16))));  // 0
    emit(encImm(CondAl, cpuIsaPkg::B, 4'd0, 16'd4));
    emit(encImm(CondAl, cpuIsaPkg::MOV, 4'd1, 16'hdead));           // Skipped
    emit(encImm(CondAl, cpuIsaPkg::MOV, 4'd2, 16'hbeef));           // Skipped
    emit(encOp(CondAl, cpuIsaPkg::ADD, 1'b0, 4'd3, 4'd1, 4'd1, 5'd0));  // 4
    emit(encImm(CondAl, cpuIsaPkg::B, 4'd0, 16'd8));
    emit(encImm(CondAl, cpuIsaPkg::MOV, 4'd3, 16'h0));
    emit(encOp(CondAl, cpuIsaPkg::HALT, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0));  // Skipped
    emit(encImm(CondAl, cpuIsaPkg::MOV, 4'd4, 16'(randBits(16))));  // 8
    emit(encOp(CondAl, cpuIsaPkg::HALT, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0));
    runProgram("forward branches");
  endtask

  // Twenty random non-branch, non-memory instructions, run twice
  task automatic randomTest();
    logic [31:0] w;
    logic [3:0]  op;
    progLen = 0;
    for (int i = 0; i < 20; i++)
    begin
      w  = randBits(32);
      op = 4'(randBits(4));
      if (op >= cpuIsaPkg::LDR && op <= cpuIsaPkg::B) op = op - 4'h8;  // LDR, STR, B remapped
      if (op == cpuIsaPkg::HALT) op = cpuIsaPkg::MOV;
      w[27:24] = op;
      w[31:28] = nextBit() ? CondAl : 4'(randBits(4));  // Mostly unconditional
      emit(w);
    end
    emit(encOp(CondAl, cpuIsaPkg::HALT, 1'b0, 4'd0, 4'd0, 4'd0, 5'd0));
    runProgram("random program, first run");
    runProgram("random program, second run");
  endtask

  // Wait for HALT if the test ran, then compare state with the model
  task automatic checkTest();
    int cycles;
    int startErrs;
    startErrs = errCount;
    cycles    = 0;
    if (expectRun)
    begin
      do
      begin
        @(negedge clk);
        cycles++;  // One retire per edge after the run edge
      end while (!halted && cycles < 1000);
    end
    else
    begin
      @(negedge clk);
    end
    if (expectRun && !halted)
      abortRun($sformatf("Test %s never reached HALT", testName));
    else
    begin
      if (expectRun)
        checkVal("halt cycle count", 32'(mRetired), 32'(cycles));
      checkVal("halted_o", 32'(expectRun), 32'(halted));
      checkVal("pc_o", 32'(mHaltPc), 32'(pc));
      checkVal("flags_o", 32'(mFlags), 32'(flags));
      for (int r = 0; r < 16; r++)
      begin
        @(negedge clk);
        dbgRegAddr = 4'(r);
        @(posedge clk);  // Core idle, data settled
        checkVal($sformatf("dbgRegData_o[r%0d]", r), mRegs[r], dbgRegData);
      end
      $display("Test %0d (%s): %0d mismatches", doneCount + 1, testName, errCount - startErrs);
      doneCount++;
    end
  endtask

  initial
  begin : stimulus
    clk        = 1'b0;
    rstN       = 1'b0;
    progWe     = 1'b0;
    progAddr   = '0;
    progData   = '0;
    run        = 1'b0;
    dbgRegAddr = '0;
    reqCount   = 0;
    doneCount  = 0;
    checkCount = 0;
    errCount   = 0;
    mFlags     = '0;
    mHaltPc    = '0;
    mRetired   = 0;
    for (int i = 0; i < 16; i++)
    begin
      mRegs[i] = '0;
    end
    repeat (5) @(negedge clk);  // Reset for 5 cycles
    rstN = 1'b1;
    requestCheck("reset state", 1'b0);
    aluTest();
    for (int k = 0; k < 8; k++)
    begin
      condTest(k);
    end
    memTest();
    branchTest();
    randomTest();
    if (!stopped)
      finishRun();
  end

  // Compare process, one pass per request
  initial
  begin : compareProc
    int t;
    while (!stopped)
    begin
      t = 0;
      while (reqCount == doneCount && t < 5000)
      begin
        @(posedge clk);
        t++;
      end
      if (reqCount == doneCount)
        abortRun("Checker waited too long for the next test");
      else
        checkTest();
    end
  end

endmodule

//--- flist.f
+incdir+common
common/cpuIsaPkg.sv
common/cpuDataPkg.sv
common/cpuIfs.sv
hw/wordRam.sv
hw/regBank.sv
hw/alu/masterAlu.sv
hw/memControl.sv
hw/control/cpuControl.sv
hw/masterCpu.sv
bench/tbMasterCpu.sv

//--- Bender.yml
package:
  name: master_cpu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cpuIsaPkg.sv
      - common/cpuDataPkg.sv
      - common/cpuIfs.sv
      - hw/wordRam.sv
      - hw/regBank.sv
      - hw/alu/masterAlu.sv
      - hw/memControl.sv
      - hw/control/cpuControl.sv
      - hw/masterCpu.sv
  - target: test
    files:
      - bench/tbMasterCpu.sv
